//--- hw/aes_pkg.sv
// AES-128 package with the block, word and byte types plus the S-box and xtime functions
`default_nettype none

package aes_pkg;

  typedef logic [127:0] aes_block_t;
  typedef logic [31:0]  aes_word_t;
  typedef logic [7:0]   aes_byte_t;

  localparam int unsigned N_ROUNDS = 10;

  // Forward S-box, entry 0 in the leftmost byte
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic aes_byte_t aes_sbox(input aes_byte_t b);
    return SBOX[b];
  endfunction

  // Multiply by x in GF(2^8)
  function automatic aes_byte_t aes_xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

`default_nettype wire

//--- hw/aes_ctrl_pkg.sv
// Controller package with the register map, the sequencer states and the event width
`default_nettype none

package aes_ctrl_pkg;

  // Word offsets on the register port
  localparam logic [3:0] REG_SRC     = 4'h0;
  localparam logic [3:0] REG_DST     = 4'h1;
  localparam logic [3:0] REG_NBLK    = 4'h2;
  localparam logic [3:0] REG_KEY0    = 4'h4;
  localparam logic [3:0] REG_KEY1    = 4'h5;
  localparam logic [3:0] REG_KEY2    = 4'h6;
  localparam logic [3:0] REG_KEY3    = 4'h7;
  localparam logic [3:0] REG_TRIGGER = 4'h8;
  localparam logic [3:0] REG_STATUS  = 4'h9;

  localparam int unsigned EVT_W = 1;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    INIT,
    ROUND,
    STORE,
    DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/aes_ifs.sv
// Transfer and round interfaces between the sequencer, counter, streamer and engine
`timescale 1ns/10ps
`default_nettype none

interface aes_xfer_if #(
  parameter int unsigned BLK_CNT_W = 8
);
  logic                 load;
  logic                 store;
  logic                 done;
  logic [BLK_CNT_W-1:0] block_idx;

  modport seq  (output load, output store, input done);
  modport cnt  (output block_idx, input store, input done);
  modport xfer (input load, input store, input block_idx, output done);
endinterface

interface aes_round_if;
  import aes_pkg::*;

  logic      init;
  logic      step;
  logic      last;
  aes_byte_t rcon;

  modport seq (output init, output step, input last);
  modport cnt (input init, input step, output last, output rcon);
  modport eng (input init, input step, input last, input rcon);
endinterface

`default_nettype wire

//--- hw/aes_regfile.sv
// Register port slave holding the job setup, raising start and reporting status
`timescale 1ns/10ps
`default_nettype none

module aes_regfile #(
  parameter int unsigned BLK_CNT_W = 8
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 periph_req_i,
  input  logic                 periph_we_i,
  input  logic [3:0]           periph_addr_i,
  input  aes_pkg::aes_word_t   periph_wdata_i,
  output aes_pkg::aes_word_t   periph_rdata_o,
  input  logic                 busy_i,
  input  logic                 done_evt_i,
  output logic                 start_o,
  output logic [31:0]          src_addr_o,
  output logic [31:0]          dst_addr_o,
  output logic [BLK_CNT_W-1:0] nblk_o,
  output aes_pkg::aes_block_t  key_o
);
  import aes_pkg::*;
  import aes_ctrl_pkg::*;

  logic [31:0]          src_q;
  logic [31:0]          dst_q;
  logic [BLK_CNT_W-1:0] nblk_q;
  aes_block_t           key_q;
  aes_word_t            rdata_q;
  logic                 start_q;
  logic                 done_q;
  logic                 wr_en;

  assign wr_en = periph_req_i && periph_we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // Trigger only counts while idle
      start_q <= wr_en && (periph_addr_i == REG_TRIGGER) && !busy_i && !start_q;
      if (start_q) begin
        done_q <= 1'b0;
      end else if (done_evt_i) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      case (periph_addr_i)
        REG_SRC:  src_q <= periph_wdata_i;
        REG_DST:  dst_q <= periph_wdata_i;
        REG_NBLK: nblk_q <= periph_wdata_i[BLK_CNT_W-1:0];
        REG_KEY0: key_q[127:96] <= periph_wdata_i;
        REG_KEY1: key_q[95:64] <= periph_wdata_i;
        REG_KEY2: key_q[63:32] <= periph_wdata_i;
        REG_KEY3: key_q[31:0] <= periph_wdata_i;
        default:  ;
      endcase
    end
    // Key words fall to the default and read as zero
    if (periph_req_i && !periph_we_i) begin
      case (periph_addr_i)
        REG_SRC:    rdata_q <= src_q;
        REG_DST:    rdata_q <= dst_q;
        REG_NBLK:   rdata_q <= 32'(nblk_q);
        REG_STATUS: rdata_q <= {30'd0, done_q, busy_i};
        default:    rdata_q <= '0;
      endcase
    end
  end

  assign periph_rdata_o = rdata_q;
  assign start_o        = start_q;
  assign src_addr_o     = src_q;
  assign dst_addr_o     = dst_q;
  assign nblk_o         = nblk_q;
  assign key_o          = key_q;

endmodule

`default_nettype wire

//--- hw/aes_ctrl_fsm.sv
// Job sequencer stepping each block through load, encrypt and store
`timescale 1ns/10ps
`default_nettype none

module aes_ctrl_fsm #(
  parameter int unsigned BLK_CNT_W = 8
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           start_i,
  input  logic [BLK_CNT_W-1:0]           nblk_i,
  aes_xfer_if.seq                        xfer,
  aes_round_if.seq                       rnd,
  input  logic                           last_blk_i,
  output logic                           busy_o,
  output logic                           done_evt_o,
  output logic [aes_ctrl_pkg::EVT_W-1:0] evt_o
);
  import aes_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        load_q;
  logic        store_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Empty job finishes at once
        if (start_i) begin
          state_d = (nblk_i == '0) ? DONE : LOAD;
        end
      end
      LOAD:  if (xfer.done) state_d = INIT;
      INIT:  state_d = ROUND;
      ROUND: if (rnd.last) state_d = STORE;
      STORE: begin
        if (xfer.done) begin
          state_d = last_blk_i ? DONE : LOAD;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      load_q  <= 1'b0;
      store_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // One pulse on entry into a transfer state
      load_q  <= (state_d == LOAD) && (state_q != LOAD);
      store_q <= (state_d == STORE) && (state_q != STORE);
    end
  end

  assign xfer.load  = load_q;
  assign xfer.store = store_q;
  assign rnd.init   = state_q == INIT;
  assign rnd.step   = state_q == ROUND;
  assign busy_o     = state_q != IDLE;
  assign done_evt_o = state_q == DONE;
  assign evt_o      = {EVT_W{done_evt_o}};

endmodule

`default_nettype wire

//--- hw/aes_progress_counter.sv
// Round and block counter giving the round constant and the last-round and last-block flags
`timescale 1ns/10ps
`default_nettype none

module aes_progress_counter #(
  parameter int unsigned BLK_CNT_W = 8
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic [BLK_CNT_W-1:0] nblk_i,
  aes_xfer_if.cnt              xfer,
  aes_round_if.cnt             rnd,
  output logic                 last_blk_o
);
  import aes_pkg::*;

  logic [3:0]           round_q;
  aes_byte_t            rcon_q;
  logic [BLK_CNT_W-1:0] blk_q;
  logic                 store_pend_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      round_q <= '0;
      rcon_q  <= 8'h01;
    end else if (rnd.init) begin
      round_q <= '0;
      rcon_q  <= 8'h01;
    end else if (rnd.step) begin
      round_q <= round_q + 4'd1;
      rcon_q  <= aes_xtime(rcon_q);
    end
  end

  assign rnd.last = rnd.step && (round_q == 4'(N_ROUNDS - 1));
  assign rnd.rcon = rcon_q;

  // Block index moves on when a store completes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      blk_q        <= '0;
      store_pend_q <= 1'b0;
    end else if (start_i) begin
      blk_q        <= '0;
      store_pend_q <= 1'b0;
    end else if (xfer.store) begin
      store_pend_q <= 1'b1;
    end else if (xfer.done && store_pend_q) begin
      store_pend_q <= 1'b0;
      blk_q        <= blk_q + 1'b1;
    end
  end

  assign xfer.block_idx = blk_q;
  assign last_blk_o     = blk_q == (nblk_i - 1'b1);

endmodule

`default_nettype wire

//--- hw/aes_streamer.sv
// Memory master gathering a 128-bit block from four words and writing results back
`timescale 1ns/10ps
`default_nettype none

module aes_streamer #(
  parameter int unsigned BLK_CNT_W = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [31:0]         src_addr_i,
  input  logic [31:0]         dst_addr_i,
  aes_xfer_if.xfer            xfer,
  output aes_pkg::aes_block_t blk_o,
  input  aes_pkg::aes_block_t blk_i,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [31:0]         mem_addr_o,
  output aes_pkg::aes_word_t  mem_wdata_o,
  input  logic                mem_gnt_i,
  input  aes_pkg::aes_word_t  mem_rdata_i,
  input  logic                mem_rvalid_i
);
  import aes_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } strm_state_e;

  strm_state_e          state_q;
  logic [1:0]           word_q;
  logic                 we_q;
  logic                 done_q;
  logic [31:0]          base_q;
  aes_block_t           gather_q;
  logic [BLK_CNT_W+3:0] blk_ofs;
  logic                 last_word;

  // Each block occupies a 16-byte slot
  assign blk_ofs     = {xfer.block_idx, 4'h0};
  assign last_word   = word_q == 2'd3;
  assign mem_addr_o  = base_q + 32'(blk_ofs) + {28'd0, word_q, 2'b00};
  assign mem_req_o   = state_q == S_REQ;
  assign mem_we_o    = we_q;
  assign mem_wdata_o = blk_i[32 * (3 - int'(word_q)) +: 32];
  assign xfer.done   = done_q;
  assign blk_o       = gather_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      word_q  <= '0;
      we_q    <= 1'b0;
      done_q  <= 1'b0;
      base_q  <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (xfer.load || xfer.store) begin
            state_q <= S_REQ;
            word_q  <= '0;
            we_q    <= xfer.store;
            base_q  <= xfer.store ? dst_addr_i : src_addr_i;
          end
        end
        S_REQ: begin
          // Writes finish on grant, reads wait for data
          if (mem_gnt_i) begin
            if (!we_q) begin
              state_q <= S_WAIT;
            end else if (last_word) begin
              state_q <= S_IDLE;
              done_q  <= 1'b1;
            end else begin
              word_q <= word_q + 2'd1;
            end
          end
        end
        S_WAIT: begin
          if (mem_rvalid_i) begin
            if (last_word) begin
              state_q <= S_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= S_REQ;
              word_q  <= word_q + 2'd1;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Word 0 lands in the top bits
  always_ff @(posedge clk_i) begin
    if (state_q == S_WAIT && mem_rvalid_i) begin
      gather_q[32 * (3 - int'(word_q)) +: 32] <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/aes_engine.sv
// Iterative AES-128 round datapath with on-the-fly key expansion
`timescale 1ns/10ps
`default_nettype none

module aes_engine (
  input  logic                clk_i,
  input  logic                arst_n_i,
  aes_round_if.eng            rnd,
  input  aes_pkg::aes_block_t key_i,
  input  aes_pkg::aes_block_t blk_i,
  output aes_pkg::aes_block_t blk_o
);
  import aes_pkg::*;

  aes_block_t state_q;
  aes_block_t state_d;
  aes_block_t rkey_q;
  aes_block_t rkey_d;
  aes_word_t  key_tmp;
  aes_byte_t  sb [16];
  aes_byte_t  sr [16];

  function automatic aes_word_t sub_word(input aes_word_t w);
    return {aes_sbox(w[31:24]), aes_sbox(w[23:16]), aes_sbox(w[15:8]), aes_sbox(w[7:0])};
  endfunction

  function automatic aes_word_t mix_column(input aes_word_t col);
    aes_byte_t a0;
    aes_byte_t a1;
    aes_byte_t a2;
    aes_byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3,
            aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3)};
  endfunction

  // RotWord, SubWord and round constant on the last key word
  assign key_tmp = sub_word({rkey_q[23:0], rkey_q[31:24]}) ^ {rnd.rcon, 24'h0};

  always_comb begin
    aes_word_t col;
    rkey_d[127:96] = rkey_q[127:96] ^ key_tmp;
    rkey_d[95:64]  = rkey_q[95:64] ^ rkey_d[127:96];
    rkey_d[63:32]  = rkey_q[63:32] ^ rkey_d[95:64];
    rkey_d[31:0]   = rkey_q[31:0] ^ rkey_d[63:32];

    // SubBytes, byte 0 in the top bits
    for (int i = 0; i < 16; i++) begin
      sb[i] = aes_sbox(state_q[127 - 8 * i -: 8]);
    end

    // ShiftRows, row r rotates left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr[4 * c + r] = sb[4 * ((c + r) % 4) + r];
      end
    end

    // MixColumns is left out in the final round
    for (int c = 0; c < 4; c++) begin
      col = {sr[4 * c], sr[4 * c + 1], sr[4 * c + 2], sr[4 * c + 3]};
      state_d[127 - 32 * c -: 32] = (rnd.last ? col : mix_column(col)) ^
                                    rkey_d[127 - 32 * c -: 32];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= '0;
      rkey_q  <= '0;
    end else if (rnd.init) begin
      // Initial AddRoundKey
      state_q <= blk_i ^ key_i;
      rkey_q  <= key_i;
    end else if (rnd.step) begin
      state_q <= state_d;
      rkey_q  <= rkey_d;
    end
  end

  assign blk_o = state_q;

endmodule

`default_nettype wire

//--- hw/aes_top.sv
// AES-128 accelerator top joining register file, sequencer, counter, streamer and engine
`timescale 1ns/10ps
`default_nettype none

module aes_top #(
  parameter int unsigned BLK_CNT_W = 8
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           periph_req_i,
  input  logic                           periph_we_i,
  input  logic [3:0]                     periph_addr_i,
  input  aes_pkg::aes_word_t             periph_wdata_i,
  output aes_pkg::aes_word_t             periph_rdata_o,
  output logic                           mem_req_o,
  output logic                           mem_we_o,
  output logic [31:0]                    mem_addr_o,
  output aes_pkg::aes_word_t             mem_wdata_o,
  input  logic                           mem_gnt_i,
  input  aes_pkg::aes_word_t             mem_rdata_i,
  input  logic                           mem_rvalid_i,
  output logic [aes_ctrl_pkg::EVT_W-1:0] evt_o
);
  import aes_pkg::*;

  logic                 start;
  logic                 busy;
  logic                 done_evt;
  logic                 last_blk;
  logic [31:0]          src_addr;
  logic [31:0]          dst_addr;
  logic [BLK_CNT_W-1:0] nblk;
  aes_block_t           key;
  aes_block_t           pt_blk;
  aes_block_t           ct_blk;

  aes_xfer_if #(.BLK_CNT_W(BLK_CNT_W)) xfer_if ();
  aes_round_if round_if ();

  aes_regfile #(
    .BLK_CNT_W      ( BLK_CNT_W      )
  ) i_regfile (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .periph_req_i   ( periph_req_i   ),
    .periph_we_i    ( periph_we_i    ),
    .periph_addr_i  ( periph_addr_i  ),
    .periph_wdata_i ( periph_wdata_i ),
    .periph_rdata_o ( periph_rdata_o ),
    .busy_i         ( busy           ),
    .done_evt_i     ( done_evt       ),
    .start_o        ( start          ),
    .src_addr_o     ( src_addr       ),
    .dst_addr_o     ( dst_addr       ),
    .nblk_o         ( nblk           ),
    .key_o          ( key            )
  );

  aes_ctrl_fsm #(
    .BLK_CNT_W  ( BLK_CNT_W    )
  ) i_ctrl_fsm (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .start_i    ( start        ),
    .nblk_i     ( nblk         ),
    .xfer       ( xfer_if.seq  ),
    .rnd        ( round_if.seq ),
    .last_blk_i ( last_blk     ),
    .busy_o     ( busy         ),
    .done_evt_o ( done_evt     ),
    .evt_o      ( evt_o        )
  );

  aes_progress_counter #(
    .BLK_CNT_W  ( BLK_CNT_W    )
  ) i_counter (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .start_i    ( start        ),
    .nblk_i     ( nblk         ),
    .xfer       ( xfer_if.cnt  ),
    .rnd        ( round_if.cnt ),
    .last_blk_o ( last_blk     )
  );

  aes_streamer #(
    .BLK_CNT_W    ( BLK_CNT_W    )
  ) i_streamer (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .src_addr_i   ( src_addr     ),
    .dst_addr_i   ( dst_addr     ),
    .xfer         ( xfer_if.xfer ),
    .blk_o        ( pt_blk       ),
    .blk_i        ( ct_blk       ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .mem_rvalid_i ( mem_rvalid_i )
  );

  aes_engine i_engine (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .rnd      ( round_if.eng ),
    .key_i    ( key          ),
    .blk_i    ( pt_blk       ),
    .blk_o    ( ct_blk       )
  );

endmodule

`default_nettype wire

//--- test/aes_tb.sv
// Testbench for the AES-128 accelerator with memory model, register driver and trace checks
`timescale 1ns/10ps
`default_nettype none

module aes_tb;
  import aes_pkg::*;
  import aes_ctrl_pkg::*;

  localparam int unsigned BLK_CNT_W = 8;
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MAX_LINES = 16;
  localparam int unsigned TIMEOUT   = 4000;
  localparam logic [31:0] SRC_BASE  = 32'h0000_0100;
  localparam logic [31:0] DST_BASE  = 32'h0000_0280;

  logic             clk_i;
  logic             arst_n_i;
  logic             periph_req_i;
  logic             periph_we_i;
  logic [3:0]       periph_addr_i;
  aes_word_t        periph_wdata_i;
  aes_word_t        periph_rdata_o;
  logic             mem_req_o;
  logic             mem_we_o;
  logic [31:0]      mem_addr_o;
  aes_word_t        mem_wdata_o;
  logic             mem_gnt_i = 1'b0;
  aes_word_t        mem_rdata_i = '0;
  logic             mem_rvalid_i = 1'b0;
  logic [EVT_W-1:0] evt_o;

  aes_word_t   mem [MEM_WORDS];
  aes_block_t  trace_raw [4 * MAX_LINES];
  logic [1:0]  gnt_delay_tab [256];
  logic [1:0]  rv_delay_tab [256];
  int unsigned evt_count = 0;
  int unsigned req_count = 0;

  // Memory model state
  logic        req_open = 1'b0;
  logic [31:0] held_addr;
  logic        held_we;
  aes_word_t   held_wdata;
  logic [7:0]  tab_idx = '0;
  int unsigned gnt_wait = 0;
  int unsigned rv_wait = 0;
  aes_word_t   rv_data;

  aes_top #(
    .BLK_CNT_W      ( BLK_CNT_W      )
  ) aes_top_inst (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .periph_req_i   ( periph_req_i   ),
    .periph_we_i    ( periph_we_i    ),
    .periph_addr_i  ( periph_addr_i  ),
    .periph_wdata_i ( periph_wdata_i ),
    .periph_rdata_o ( periph_rdata_o ),
    .mem_req_o      ( mem_req_o      ),
    .mem_we_o       ( mem_we_o       ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .mem_rvalid_i   ( mem_rvalid_i   ),
    .evt_o          ( evt_o          )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  task automatic halt_on_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input string name, input aes_word_t got, input aes_word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      halt_on_failure();
    end
  endtask

  task automatic check_block(input string name, input aes_block_t got,
                             input aes_block_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      halt_on_failure();
    end
  endtask

  // Background pattern tied to every address bit
  function automatic aes_word_t fill_word(input logic [31:0] addr);
    return addr ^ 32'ha5c3_0000 ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic int unsigned word_index(input logic [31:0] addr);
    return int'(addr >> 2);
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(32'(i) << 2);
    end
  endtask

  task automatic reg_write(input logic [3:0] addr, input aes_word_t data);
    @(posedge clk_i);
    periph_req_i   <= 1'b1;
    periph_we_i    <= 1'b1;
    periph_addr_i  <= addr;
    periph_wdata_i <= data;
    @(posedge clk_i);
    periph_req_i   <= 1'b0;
    periph_we_i    <= 1'b0;
  endtask

  // Read data shows up one cycle after the request
  task automatic reg_read(input logic [3:0] addr, output aes_word_t data);
    @(posedge clk_i);
    periph_req_i  <= 1'b1;
    periph_we_i   <= 1'b0;
    periph_addr_i <= addr;
    @(posedge clk_i);
    periph_req_i  <= 1'b0;
    @(posedge clk_i);
    data = periph_rdata_o;
  endtask

  task automatic wait_for_events(input int unsigned count);
    int unsigned cycles;
    cycles = 0;
    while (evt_count < count) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout while waiting for the completion event");
        halt_on_failure();
      end
    end
  endtask

  task automatic run_job(input int unsigned first, input int unsigned nblk,
                         input int unsigned evt_exp);
    aes_word_t   rd;
    aes_block_t  got;
    logic [31:0] addr;
    fill_memory();
    for (int b = 0; b < nblk; b++) begin
      for (int w = 0; w < 4; w++) begin
        addr = SRC_BASE + 32'(16 * b + 4 * w);
        mem[word_index(addr)] = trace_raw[4 * (first + b) + 2][127 - 32 * w -: 32];
      end
    end
    reg_write(REG_SRC, SRC_BASE);
    reg_write(REG_DST, DST_BASE);
    reg_write(REG_NBLK, 32'(nblk));
    for (int k = 0; k < 4; k++) begin
      reg_write(4'(REG_KEY0 + k), trace_raw[4 * first + 1][127 - 32 * k -: 32]);
    end
    reg_write(REG_TRIGGER, 32'h1);
    reg_read(REG_STATUS, rd);
    check_word("status_busy", rd, 32'h1);
    // Second trigger lands while busy
    reg_write(REG_TRIGGER, 32'h1);
    wait_for_events(evt_exp);
    reg_read(REG_STATUS, rd);
    check_word("status_done", rd, 32'h2);
    for (int b = 0; b < nblk; b++) begin
      addr = DST_BASE + 32'(16 * b);
      got = {mem[word_index(addr)], mem[word_index(addr + 4)],
             mem[word_index(addr + 8)], mem[word_index(addr + 12)]};
      check_block("ct_block", got, trace_raw[4 * (first + b) + 3]);
    end
    addr = DST_BASE + 32'(16 * nblk);
    check_word("mem_after_region", mem[word_index(addr)], fill_word(addr));
    repeat (40) @(posedge clk_i);
    check_word("evt_count", evt_count, evt_exp);
  endtask

  always @(posedge clk_i) begin
    if (|evt_o) begin
      evt_count <= evt_count + 1;
    end
  end

  // Memory model with random grant and read-valid delays
  always @(posedge clk_i) begin
    mem_gnt_i    <= 1'b0;
    mem_rvalid_i <= 1'b0;
    if (mem_req_o) begin
      if (!req_open) begin
        req_open   = 1'b1;
        held_addr  = mem_addr_o;
        held_we    = mem_we_o;
        held_wdata = mem_wdata_o;
        gnt_wait   = gnt_delay_tab[tab_idx];
        req_count <= req_count + 1;
      end else begin
        check_word("mem_addr_o", mem_addr_o, held_addr);
        check_word("mem_we_o", 32'(mem_we_o), 32'(held_we));
        if (held_we) begin
          check_word("mem_wdata_o", mem_wdata_o, held_wdata);
        end
      end
      if (mem_gnt_i) begin
        req_open = 1'b0;
        if (word_index(mem_addr_o) >= MEM_WORDS || mem_addr_o[1:0] != 2'b00) begin
          $display("Memory access outside the modelled region");
          halt_on_failure();
        end
        if (mem_we_o) begin
          mem[word_index(mem_addr_o)] = mem_wdata_o;
        end else begin
          rv_data = mem[word_index(mem_addr_o)];
          rv_wait = rv_delay_tab[tab_idx];
        end
        tab_idx = tab_idx + 8'd1;
      end else if (gnt_wait == 0) begin
        mem_gnt_i <= 1'b1;
      end else begin
        gnt_wait--;
      end
    end
    if (rv_wait != 0) begin
      rv_wait--;
      if (rv_wait == 0) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= rv_data;
      end
    end
  end

  initial begin
    aes_word_t   rd;
    int unsigned n_lines;
    int unsigned first;
    int unsigned last_line;
    int unsigned jobs_done;
    int unsigned reqs_before;
    void'($urandom(32'h4194_0d33));
    for (int i = 0; i < 256; i++) begin
      gnt_delay_tab[i] = 2'($urandom % 4);
      rv_delay_tab[i]  = 2'(1 + $urandom % 3);
    end
    arst_n_i       = 1'b0;
    periph_req_i   = 1'b0;
    periph_we_i    = 1'b0;
    periph_addr_i  = '0;
    periph_wdata_i = '0;
    fill_memory();
    for (int i = 0; i < 4 * MAX_LINES; i++) begin
      trace_raw[i] = '1;
    end
    $readmemh("test/aes_trace.txt", trace_raw);
    n_lines = 0;
    while (n_lines < MAX_LINES && trace_raw[4 * n_lines] !== '1) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      $display("No vectors were found in the trace file");
      halt_on_failure();
    end
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    // Lines with one job number form one job
    jobs_done = 0;
    first = 0;
    while (first < n_lines) begin
      last_line = first;
      while (last_line < n_lines && trace_raw[4 * last_line] == trace_raw[4 * first]) begin
        last_line++;
      end
      jobs_done++;
      run_job(first, last_line - first, jobs_done);
      first = last_line;
    end

    // Empty job touches no memory
    reqs_before = req_count;
    reg_write(REG_NBLK, 32'h0);
    reg_write(REG_TRIGGER, 32'h1);
    wait_for_events(jobs_done + 1);
    reg_read(REG_STATUS, rd);
    check_word("status_done", rd, 32'h2);
    repeat (20) @(posedge clk_i);
    check_word("mem_req_count", req_count, reqs_before);
    check_word("evt_count", evt_count, jobs_done + 1);
    for (int k = 0; k < 4; k++) begin
      reg_read(4'(REG_KEY0 + k), rd);
      check_word("key_readback", rd, 32'h0);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/aes_trace.txt
// Columns: job number, key, plaintext, expected ciphertext (all hex), one block per line
// Consecutive lines with the same job number form one job under one key

// FIPS-197 appendix B
0 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32

// FIPS-197 appendix C.1
1 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a

// All-zero key and block
2 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e

// Four blocks under one key
3 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
3 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
3 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
3 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4

//--- project.f
hw/aes_pkg.sv
hw/aes_ctrl_pkg.sv
hw/aes_ifs.sv
hw/aes_regfile.sv
hw/aes_ctrl_fsm.sv
hw/aes_progress_counter.sv
hw/aes_streamer.sv
hw/aes_engine.sv
hw/aes_top.sv
test/aes_tb.sv

//--- Makefile
# Verilator build and run, lint and clean
TOP := aes_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f hw/*.sv test/aes_tb.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /NO ERRORS/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module aes_top -f project.f

clean:
	rm -rf obj_dir
